/* rtl/ls_pkg.sv */
// Shared types and constants for the load/store slice
// Operations are 15 bits wide and come in a word layout and a sub-word layout
// The local memory depth must be a power of two

package ls_pkg;

  // Number of general registers visible to the load/store unit
  localparam int LS_NREGS = 8;

  // Local data memory depth in 32-bit words
  localparam int LS_DMEM_WORDS = 256;

  // Top address nibbles that route to the external request port
  localparam logic [3:0] LS_AXI_SPACE     = 4'hF;
  localparam logic [3:0] LS_RACCOON_SPACE = 4'hE;

  // Word access layout, selected when the word bit is set
  // The offset is scaled by four before use
  typedef struct packed {
    logic       store;
    logic       upd;
    logic       word;
    logic [5:0] off6;
    logic [2:0] ptr_sel;
    logic [2:0] reg_sel;
  } ls_op_word_t;

  // Halfword and byte layout, selected when the word bit is clear
  // The offset is scaled by two for halfwords and used as is for bytes
  typedef struct packed {
    logic       store;
    logic       upd;
    logic       word;
    logic       half;
    logic [4:0] off5;
    logic [2:0] ptr_sel;
    logic [2:0] reg_sel;
  } ls_op_sub_t;

  // The same operation word seen through either layout
  // Store, upd, word and both selects sit at the same bits in both views
  typedef union packed {
    ls_op_word_t w;
    ls_op_sub_t  s;
  } ls_op_u;

  // One register write event
  typedef struct packed {
    logic        vld;
    logic [2:0]  sel;
    logic [31:0] data;
  } ls_reg_wr_t;

  // No-wait data bus request, with the address always word aligned
  typedef struct packed {
    logic        dcs;
    logic        axi_cs;
    logic        raccoon_cs;
    logic        wr;
    logic [3:0]  mask;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [2:0]  wb_sel;
  } ls_dbus_t;

endpackage

/* rtl/ls_unit.sv */
// Load/store unit with a fixed three cycle load latency and no stalls
// Only loads to the local memory write back, external loads are dropped
// Register reads are combinational and see only values already written

`timescale 1ns/10ps

module ls_unit
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              op_vld,
  input  ls_pkg::ls_op_u    op,
  output logic [2:0]        ptr_sel,
  output logic [2:0]        store_sel,
  input  logic [31:0]       ptr,
  input  logic [31:0]       store_data,
  output ls_pkg::ls_dbus_t  dbus,
  input  logic [31:0]       rdata,
  output ls_pkg::ls_reg_wr_t ptr_upd,
  output ls_pkg::ls_reg_wr_t load_wb
);

  import ls_pkg::*;

  // Load tag carried alongside the memory access until the data returns
  typedef struct packed {
    logic       vld;
    logic       word;
    logic       half;
    logic [1:0] lo;
    logic [2:0] sel;
  } ld_tag_t;

  logic [31:0] off_zx;
  logic [31:0] off_sx;
  logic [31:0] addr_next;
  logic [31:0] addr_out;
  logic [31:0] wr_data;
  logic [3:0]  lane_mask;
  logic        axi_space;
  logic        raccoon_space;
  logic        is_half;
  ld_tag_t     tag_d1;
  ld_tag_t     tag_d2;
  ld_tag_t     tag_d3;
  logic [31:0] rd_q;
  logic [31:0] rd_align;

  // Both selects share their position in either layout
  assign ptr_sel   = op.w.ptr_sel;
  assign store_sel = op.w.reg_sel;

  // The half bit only exists in the sub-word view
  assign is_half = !op.w.word && op.s.half;

  // Offset scaling and extension per access size
  always_comb
  begin
    if (op.w.word)
    begin
      off_zx = {24'd0, op.w.off6, 2'b00};
      off_sx = {{24{op.w.off6[5]}}, op.w.off6, 2'b00};
    end
    else if (op.s.half)
    begin
      off_zx = {26'd0, op.s.off5, 1'b0};
      off_sx = {{26{op.s.off5[4]}}, op.s.off5, 1'b0};
    end
    else
    begin
      off_zx = {27'd0, op.s.off5};
      off_sx = {{27{op.s.off5[4]}}, op.s.off5};
    end
  end

  // Updating forms use the signed offset, plain forms the unsigned one
  assign addr_next = ptr + (op.w.upd ? off_sx : off_zx);

  // Post-increment uses the old pointer, pre-decrement the new one
  assign addr_out = (op.w.upd && !off_sx[31]) ? ptr : addr_next;

  assign axi_space     = (addr_out[31:28] == LS_AXI_SPACE);
  assign raccoon_space = (addr_out[31:28] == LS_RACCOON_SPACE);

  // Lane mask and replicated store data
  always_comb
  begin
    if (op.w.word)
    begin
      lane_mask = 4'b1111;
      wr_data   = store_data;
    end
    else if (is_half)
    begin
      lane_mask = addr_out[1] ? 4'b1100 : 4'b0011;
      wr_data   = {2{store_data[15:0]}};
    end
    else
    begin
      lane_mask = 4'b0001 << addr_out[1:0];
      wr_data   = {4{store_data[7:0]}};
    end
  end

  // Bus request, valid the cycle after issue
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      dbus <= '0;
    else if (op_vld)
    begin
      dbus.dcs        <= !axi_space && !raccoon_space;
      dbus.axi_cs     <= axi_space;
      dbus.raccoon_cs <= raccoon_space;
      dbus.wr         <= op.w.store;
      dbus.mask       <= lane_mask;
      dbus.addr       <= {addr_out[31:2], 2'b00};
      // Loads carry no write data
      dbus.wdata      <= op.w.store ? wr_data : 32'd0;
      dbus.wb_sel     <= op.w.reg_sel;
    end
    else
      dbus <= '0;
  end

  // Pointer update event, valid together with the bus request
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      ptr_upd <= '0;
    else if (op_vld && op.w.upd)
    begin
      ptr_upd.vld  <= 1'b1;
      ptr_upd.sel  <= op.w.ptr_sel;
      ptr_upd.data <= addr_next;
    end
    else
      ptr_upd <= '0;
  end

  // Tag pipeline, the first stage only marks local loads as valid
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      tag_d1 <= '0;
      tag_d2 <= '0;
      tag_d3 <= '0;
    end
    else
    begin
      tag_d1.vld  <= op_vld && !op.w.store && !axi_space && !raccoon_space;
      tag_d1.word <= op.w.word;
      tag_d1.half <= is_half;
      tag_d1.lo   <= addr_out[1:0];
      tag_d1.sel  <= op.w.reg_sel;
      tag_d2      <= tag_d1;
      tag_d3      <= tag_d2;
    end
  end

  // Memory data arrives two cycles after issue and is held for alignment
  always_ff @(posedge CLK)
  begin
    if (tag_d2.vld)
      rd_q <= rdata;
  end

  // Shift the addressed lane down and zero-extend it
  always_comb
  begin
    if (tag_d3.word)
      rd_align = rd_q;
    else if (tag_d3.half)
      rd_align = tag_d3.lo[1] ? {16'd0, rd_q[31:16]} : {16'd0, rd_q[15:0]};
    else
    begin
      case (tag_d3.lo)
        2'd0:    rd_align = {24'd0, rd_q[7:0]};
        2'd1:    rd_align = {24'd0, rd_q[15:8]};
        2'd2:    rd_align = {24'd0, rd_q[23:16]};
        default: rd_align = {24'd0, rd_q[31:24]};
      endcase
    end
  end

  // Writeback event three cycles after issue, all fields quiet when idle
  always_comb
  begin
    load_wb.vld  = tag_d3.vld;
    load_wb.sel  = tag_d3.vld ? tag_d3.sel : 3'd0;
    load_wb.data = tag_d3.vld ? rd_align : 32'd0;
  end

endmodule

/* rtl/ls_regfile.sv */
// Eight 32-bit registers with two combinational read ports
// Writes land on the edge after the event, so reads never bypass
// Same-register priority is load writeback, pointer update, host preload

`timescale 1ns/10ps

module ls_regfile
(
  input  logic               CLK,
  input  logic               RST,
  input  logic [2:0]         ptr_sel,
  input  logic [2:0]         store_sel,
  output logic [31:0]        ptr,
  output logic [31:0]        store_data,
  input  ls_pkg::ls_reg_wr_t load_wb,
  input  ls_pkg::ls_reg_wr_t ptr_upd,
  input  ls_pkg::ls_reg_wr_t host_wr
);

  import ls_pkg::*;

  logic [31:0] regs [LS_NREGS];

  // Read ports return the stored value only
  assign ptr        = regs[ptr_sel];
  assign store_data = regs[store_sel];

  // Each register takes at most one write per edge
  // Different registers can be written by different ports at once
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < LS_NREGS; i++)
        regs[i] <= 32'd0;
    end
    else
    begin
      for (int i = 0; i < LS_NREGS; i++)
      begin
        // Load data wins over the pointer it was fetched through
        if (load_wb.vld && (load_wb.sel == 3'(i)))
          regs[i] <= load_wb.data;
        else if (ptr_upd.vld && (ptr_upd.sel == 3'(i)))
          regs[i] <= ptr_upd.data;
        else if (host_wr.vld && (host_wr.sel == 3'(i)))
          regs[i] <= host_wr.data;
      end
    end
  end

endmodule

/* rtl/ls_dmem.sv */
// Local no-wait data memory with byte-masked writes
// The word index wraps modulo the depth, upper address bits are ignored
// Read data is registered and valid the cycle after the request

`timescale 1ns/10ps

module ls_dmem
(
  input  logic             CLK,
  input  logic             RST,
  input  ls_pkg::ls_dbus_t dbus,
  output logic [31:0]      rdata
);

  import ls_pkg::*;

  localparam int AW = $clog2(LS_DMEM_WORDS);

  logic [31:0]   mem [LS_DMEM_WORDS];
  logic [AW-1:0] idx;

  // Word index from the bits above the byte offset
  assign idx = dbus.addr[AW+1:2];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < LS_DMEM_WORDS; i++)
        mem[i] <= 32'd0;
      rdata <= 32'd0;
    end
    else if (dbus.dcs)
    begin
      if (dbus.wr)
      begin
        // Only the enabled byte lanes change
        for (int b = 0; b < 4; b++)
        begin
          if (dbus.mask[b])
            mem[idx][8*b +: 8] <= dbus.wdata[8*b +: 8];
        end
      end
      else
        rdata <= mem[idx];
    end
  end

endmodule

/* rtl/ls_core_top.sv */
// Load/store slice with register file and local memory
// External space requests leave through ext_req and get no response
// No interlocks, the issuer must respect the writeback latencies

`timescale 1ns/10ps

module ls_core_top
(
  input  logic               CLK,
  input  logic               RST,
  input  logic               op_vld,
  input  ls_pkg::ls_op_u     op,
  input  ls_pkg::ls_reg_wr_t host_wr,
  output ls_pkg::ls_dbus_t   ext_req,
  output ls_pkg::ls_reg_wr_t ptr_upd,
  output ls_pkg::ls_reg_wr_t load_wb
);

  import ls_pkg::*;

  logic [2:0]  ptr_sel;
  logic [2:0]  store_sel;
  logic [31:0] ptr;
  logic [31:0] store_data;
  logic [31:0] rdata;
  ls_dbus_t    dbus;

  // Decode, address generation, bus request and load alignment
  ls_unit i_ls_unit
  (
    .CLK        (CLK),
    .RST        (RST),
    .op_vld     (op_vld),
    .op         (op),
    .ptr_sel    (ptr_sel),
    .store_sel  (store_sel),
    .ptr        (ptr),
    .store_data (store_data),
    .dbus       (dbus),
    .rdata      (rdata),
    .ptr_upd    (ptr_upd),
    .load_wb    (load_wb)
  );

  // Pointer updates and load results also leave the top as events
  ls_regfile i_ls_regfile
  (
    .CLK        (CLK),
    .RST        (RST),
    .ptr_sel    (ptr_sel),
    .store_sel  (store_sel),
    .ptr        (ptr),
    .store_data (store_data),
    .load_wb    (load_wb),
    .ptr_upd    (ptr_upd),
    .host_wr    (host_wr)
  );

  // Responds only when the local select is set
  ls_dmem i_ls_dmem
  (
    .CLK   (CLK),
    .RST   (RST),
    .dbus  (dbus),
    .rdata (rdata)
  );

  // External request is the bus word itself, zero for local traffic
  assign ext_req = (dbus.axi_cs || dbus.raccoon_cs) ? dbus : '0;

endmodule

/* sim/tb_ls_core.sv */
// Random-stimulus testbench for the load/store slice
// A cycle-timed model of registers and memory predicts every output
// Inputs change on the falling edge and outputs are sampled there too

`timescale 1ns/10ps

module tb_ls_core;

  import ls_pkg::*;

  localparam int NUM_OPS   = 400;
  localparam int DRAIN     = 6;
  localparam int WD_CYCLES = NUM_OPS * 10 + 4 + LS_NREGS + 4 + DRAIN;

  logic       CLK;
  logic       RST;
  logic       op_vld;
  ls_op_u     op;
  ls_reg_wr_t host_wr;
  ls_dbus_t   ext_req;
  ls_reg_wr_t ptr_upd;
  ls_reg_wr_t load_wb;

  integer      seed;
  int          cycle_cnt;
  int          issued;
  logic [31:0] m_regs [LS_NREGS];
  logic [31:0] m_mem  [LS_DMEM_WORDS];
  // Index 0 holds what the DUT must show in the current cycle
  ls_dbus_t    exp_ext [4];
  ls_reg_wr_t  exp_pu  [4];
  ls_reg_wr_t  exp_wb  [4];

  ls_core_top i_ls_core_top
  (
    .CLK     (CLK),
    .RST     (RST),
    .op_vld  (op_vld),
    .op      (op),
    .host_wr (host_wr),
    .ext_req (ext_req),
    .ptr_upd (ptr_upd),
    .load_wb (load_wb)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_dbus(input string name, input ls_dbus_t exp, input ls_dbus_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_reg_wr(input string name, input ls_reg_wr_t exp, input ls_reg_wr_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Kind 1 gives the E space, kind 2 the F space, anything else a local pointer
  function automatic logic [31:0] random_pointer(input int kind);
    logic [31:0] p;
    p = $random(seed);
    // Keep the low window narrow so that stores and loads overlap
    p[9:8] = 2'b01;
    case (kind)
      1:       p[31:28] = LS_RACCOON_SPACE;
      2:       p[31:28] = LS_AXI_SPACE;
      default: p[31:28] = 4'($unsigned($random(seed)) % 14);
    endcase
    return p;
  endfunction

  // Predicts the bus request, pointer update and writeback of one operation
  task automatic model_issue(input ls_op_u o);
    logic [31:0] base;
    logic [31:0] operand;
    logic [31:0] off_u;
    logic [31:0] off_s;
    logic [31:0] new_ptr;
    logic [31:0] addr;
    logic [31:0] rep;
    logic [31:0] data;
    logic [3:0]  mask;
    int          idx;
    int          shift;
    ls_dbus_t    req;
    base    = m_regs[o.w.ptr_sel];
    operand = m_regs[o.w.reg_sel];
    if (o.w.word)
    begin
      off_u = 32'(o.w.off6) * 4;
      off_s = 32'($signed(o.w.off6)) * 4;
    end
    else if (o.s.half)
    begin
      off_u = 32'(o.s.off5) * 2;
      off_s = 32'($signed(o.s.off5)) * 2;
    end
    else
    begin
      off_u = 32'(o.s.off5);
      off_s = 32'($signed(o.s.off5));
    end
    new_ptr = base + (o.w.upd ? off_s : off_u);
    // A non-negative updating offset means post-increment through the old pointer
    addr = (o.w.upd && ($signed(off_s) >= 0)) ? base : new_ptr;
    if (o.w.word)
    begin
      mask = 4'b1111;
      rep  = operand;
    end
    else if (o.s.half)
    begin
      mask = addr[1] ? 4'b1100 : 4'b0011;
      rep  = {operand[15:0], operand[15:0]};
    end
    else
    begin
      // A byte enables only the lane named by the low address bits
      mask              = 4'b0000;
      mask[addr[1:0]]   = 1'b1;
      rep               = {4{operand[7:0]}};
    end
    if (o.w.upd)
      exp_pu[1] = '{vld: 1'b1, sel: o.w.ptr_sel, data: new_ptr};
    if ((addr[31:28] == LS_AXI_SPACE) || (addr[31:28] == LS_RACCOON_SPACE))
    begin
      // External traffic is only visible on ext_req and never writes back
      req            = '0;
      req.axi_cs     = (addr[31:28] == LS_AXI_SPACE);
      req.raccoon_cs = (addr[31:28] == LS_RACCOON_SPACE);
      req.wr         = o.w.store;
      req.mask       = mask;
      req.addr       = {addr[31:2], 2'b00};
      req.wdata      = o.w.store ? rep : 32'd0;
      req.wb_sel     = o.w.reg_sel;
      exp_ext[1]     = req;
    end
    else
    begin
      // Memory accesses complete in issue order, so the model applies them now
      idx = int'((addr >> 2) % LS_DMEM_WORDS);
      if (o.w.store)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (mask[b])
            m_mem[idx][8*b +: 8] = rep[8*b +: 8];
        end
      end
      else
      begin
        if (o.w.word)
          data = m_mem[idx];
        else if (o.s.half)
        begin
          shift = addr[1] ? 16 : 0;
          data  = (m_mem[idx] >> shift) & 32'h0000_ffff;
        end
        else
        begin
          shift = 8 * int'(addr[1:0]);
          data  = (m_mem[idx] >> shift) & 32'h0000_00ff;
        end
        exp_wb[3] = '{vld: 1'b1, sel: o.w.reg_sel, data: data};
      end
    end
  endtask

  // Register writes at the closing edge, lowest priority first so later ones win
  task automatic apply_writes();
    if (host_wr.vld)
      m_regs[host_wr.sel] = host_wr.data;
    if (exp_pu[0].vld)
      m_regs[exp_pu[0].sel] = exp_pu[0].data;
    if (exp_wb[0].vld)
      m_regs[exp_wb[0].sel] = exp_wb[0].data;
  endtask

  task automatic shift_expected();
    for (int i = 0; i < 3; i++)
    begin
      exp_ext[i] = exp_ext[i + 1];
      exp_pu[i]  = exp_pu[i + 1];
      exp_wb[i]  = exp_wb[i + 1];
    end
    exp_ext[3] = '0;
    exp_pu[3]  = '0;
    exp_wb[3]  = '0;
  endtask

  // Checks the outputs of one clock cycle and then drives the next inputs
  task automatic run_cycle(input logic vld, input ls_op_u o, input ls_reg_wr_t hw);
    @(negedge CLK);
    cycle_cnt++;
    check_flag($sformatf("ptr_upd valid cycle %0d", cycle_cnt), exp_pu[0].vld, ptr_upd.vld);
    check_flag($sformatf("load_wb valid cycle %0d", cycle_cnt), exp_wb[0].vld, load_wb.vld);
    check_dbus($sformatf("ext_req cycle %0d", cycle_cnt), exp_ext[0], ext_req);
    check_reg_wr($sformatf("ptr_upd cycle %0d", cycle_cnt), exp_pu[0], ptr_upd);
    check_reg_wr($sformatf("load_wb cycle %0d", cycle_cnt), exp_wb[0], load_wb);
    op_vld  = vld;
    op      = o;
    host_wr = hw;
    if (vld)
      model_issue(o);
    apply_writes();
    shift_expected();
  endtask

  initial
  begin
    ls_op_u     o;
    ls_reg_wr_t hw;
    logic       vld;
    seed       = 32'h6dae35d9;
    cycle_cnt  = 0;
    issued     = 0;
    RST        = 1'b1;
    op_vld     = 1'b0;
    op         = '0;
    host_wr    = '0;
    for (int i = 0; i < LS_NREGS; i++)
      m_regs[i] = 32'd0;
    for (int i = 0; i < LS_DMEM_WORDS; i++)
      m_mem[i] = 32'd0;
    for (int i = 0; i < 4; i++)
    begin
      exp_ext[i] = '0;
      exp_pu[i]  = '0;
      exp_wb[i]  = '0;
    end

    // Outputs must stay quiet for the whole reset
    repeat (4)
    begin
      @(negedge CLK);
      check_dbus("ext_req in reset", '0, ext_req);
      check_flag("ptr_upd valid in reset", 1'b0, ptr_upd.vld);
      check_flag("load_wb valid in reset", 1'b0, load_wb.vld);
    end
    RST = 1'b0;

    // Registers 6 and 7 start in the E and F spaces
    for (int i = 0; i < LS_NREGS; i++)
    begin
      hw = '{vld: 1'b1, sel: 3'(i), data: random_pointer((i == 6) ? 1 : ((i == 7) ? 2 : 0))};
      o  = 15'($random(seed));
      run_cycle(1'b0, o, hw);
    end

    // Store then load the same word, and update r2 in the cycle its load lands
    o.w = '{store: 1'b1, upd: 1'b0, word: 1'b1, off6: 6'd3, ptr_sel: 3'd0, reg_sel: 3'd1};
    run_cycle(1'b1, o, '0);
    o.w = '{store: 1'b0, upd: 1'b0, word: 1'b1, off6: 6'd3, ptr_sel: 3'd0, reg_sel: 3'd2};
    run_cycle(1'b1, o, '0);
    run_cycle(1'b0, o, '0);
    o.w = '{store: 1'b0, upd: 1'b1, word: 1'b1, off6: 6'd5, ptr_sel: 3'd2, reg_sel: 3'd4};
    run_cycle(1'b1, o, '0);
    issued = 3;

    while (issued < NUM_OPS)
    begin
      vld = ($unsigned($random(seed)) % 10) < 7;
      o   = 15'($random(seed));
      hw  = '0;
      // Occasional pointer refresh keeps the external spaces in use
      if (($random(seed) & 15) == 0)
      begin
        hw.vld  = 1'b1;
        hw.sel  = 3'($random(seed));
        hw.data = random_pointer($unsigned($random(seed)) % 4);
      end
      run_cycle(vld, o, hw);
      if (vld)
        issued++;
    end

    // Let the last loads come back
    repeat (DRAIN)
      run_cycle(1'b0, '0, '0);

    $display("Verification passed");
    $finish;
  end

  initial
  begin
    #(WD_CYCLES * 8);
    $display("Watchdog expired after %0d cycles, the run did not complete", WD_CYCLES);
    abort_run();
  end

endmodule

/* ls_core.f */
rtl/ls_pkg.sv
rtl/ls_unit.sv
rtl/ls_regfile.sv
rtl/ls_dmem.sv
rtl/ls_core_top.sv
sim/tb_ls_core.sv

/* Bender.yml */
package:
  name: ls_core

sources:
  - rtl/ls_pkg.sv
  - rtl/ls_unit.sv
  - rtl/ls_regfile.sv
  - rtl/ls_dmem.sv
  - rtl/ls_core_top.sv
  - target: simulation
    files:
      - sim/tb_ls_core.sv
